//--- sources.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_unit.sv
rtl/icache.sv
rtl/fetch_top.sv
dv/axi_rom_model.sv
dv/fetch_tb.sv

//--- Bender.yml
package:
  name: fetch_subsystem

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/fetch_pkg.sv
      - rtl/fetch_unit.sv
      - rtl/icache.sv
      - rtl/fetch_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - dv/axi_rom_model.sv
      - dv/fetch_tb.sv

//--- dv/fetch_tb.sv
`include "fetch_defs.svh"

module fetch_tb
    import fetch_pkg::*;
();

    localparam int CLK_HALF        = 4;
    localparam int CLK_PERIOD      = 2 * CLK_HALF;
    localparam int DRIVE_DELAY     = 1;
    localparam int RESET_CYCLES    = 5;
    localparam int LOG_DEPTH       = 256;
    localparam int OFFSET_BITS     = $clog2(`FETCH_BLOCK_BYTES);
    localparam int BLOCK_WORDS     = `FETCH_BLOCK_BYTES / 4;

    localparam int N_SEQ           = 12;
    localparam int N_SDRAM         = 4;
    localparam int N_REUSE         = 4;
    localparam int N_BACKPRESSURE  = 48;
    localparam int N_FAULT         = 8;
    localparam int TOTAL_INSTS     = N_SEQ + N_SDRAM + N_REUSE + N_BACKPRESSURE + N_FAULT;
    localparam int CYCLES_PER_INST = 40;
    localparam int MARGIN_CYCLES   = 200;

    localparam logic [31:0] SEQ_BASE   = `FETCH_PC_RESET;
    localparam logic [31:0] SDRAM_BASE = 32'hA000_0000;
    localparam logic [31:0] REUSE_BASE = SEQ_BASE + 32'h20; // Third block, not evicted.
    localparam logic [31:0] FAULT_BASE = 32'h5000_0000;

    logic          clk;
    logic          rst;
    logic          redirect_valid;
    logic [29:0]   redirect_pc;
    logic          decode_ready;
    logic          fetch_valid;
    fetch_packet_t fetch_out;
    logic          access_fault;
    logic          arvalid;
    axi_ar_t       ar;
    logic          arready;
    logic          rready;
    logic          rvalid;
    axi_r_t        r;
    logic [29:0]   rom_addr;
    logic [31:0]   rom_data;
    logic          fault_en;
    logic [31:0]   fault_base;
    int            ar_count;

    logic [29:0]   exp_pc;
    int            delivered;
    logic          fault_armed;
    logic          fault_seen;
    logic [31:0]   rand_state;

    fetch_top dut0 (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .decode_ready   (decode_ready),
        .fetch_valid    (fetch_valid),
        .fetch_out      (fetch_out),
        .access_fault   (access_fault),
        .arvalid        (arvalid),
        .ar             (ar),
        .arready        (arready),
        .rready         (rready),
        .rvalid         (rvalid),
        .r              (r)
    );

    axi_rom_model #(.LOG_DEPTH(LOG_DEPTH)) rom0 (
        .clk        (clk),
        .rst        (rst),
        .arvalid    (arvalid),
        .ar         (ar),
        .arready    (arready),
        .rvalid     (rvalid),
        .rready     (rready),
        .r          (r),
        .rom_addr   (rom_addr),
        .rom_data   (rom_data),
        .fault_en   (fault_en),
        .fault_base (fault_base),
        .ar_count   (ar_count)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rom_word(input logic [29:0] a);
        return xorshift32(xorshift32({2'b00, a} ^ 32'h9e37_79b9));
    endfunction

    function automatic fetch_packet_t expected_packet(input logic [29:0] pc);
        fetch_packet_t p;
        p.pc   = pc;
        p.inst = rom_word(pc);
        return p;
    endfunction

    assign rom_data = rom_word(rom_addr); // ROM contents seen by the model.

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("** Error at time %0t: %s expected %h actual %h",
                     $time, name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic next_drive_point();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic wait_for_delivered(input int count);
        while (delivered < count) begin
            next_drive_point();
        end
    endtask

    // Hold the redirect until the PC has moved to the target.
    task automatic redirect_to(input logic [31:0] addr);
        redirect_pc    = addr[31:2];
        redirect_valid = 1'b1;
        do begin
            next_drive_point();
        end while (dut0.lookup_addr !== addr);
        redirect_valid = 1'b0;
        exp_pc         = addr[31:2];
    endtask

    task automatic check_single_refill(input logic [31:0] base);
        axi_ar_t beat;
        int      n;
        n = 0;
        for (int i = 0; i < ar_count && i < LOG_DEPTH; i++) begin
            beat = rom0.ar_log[i];
            if (beat.addr[31:OFFSET_BITS] == base[31:OFFSET_BITS]) begin
                check_value("ar.addr", base + 32'(4 * n), beat.addr);
                check_value("ar.len", 0, beat.len);
                check_value("ar.burst", BURST_FIXED, beat.burst);
                check_value("ar.size", 2, beat.size);
                check_value("ar.id", 0, beat.id);
                n++;
            end
        end
        check_value("ar beats per single-read block", BLOCK_WORDS, n);
    endtask

    task automatic check_burst_refill(input logic [31:0] base);
        axi_ar_t beat;
        int      n;
        n = 0;
        for (int i = 0; i < ar_count && i < LOG_DEPTH; i++) begin
            beat = rom0.ar_log[i];
            if (beat.addr[31:OFFSET_BITS] == base[31:OFFSET_BITS]) begin
                check_value("ar.addr", base, beat.addr);
                check_value("ar.len", BLOCK_WORDS - 1, beat.len);
                check_value("ar.burst", BURST_INCR, beat.burst);
                check_value("ar.size", 2, beat.size);
                check_value("ar.id", 0, beat.id);
                n++;
            end
        end
        check_value("ar beats per burst block", 1, n);
    endtask

    initial begin
        clk = 1'b0;
    end

    always #CLK_HALF clk = ~clk;

    // Every handover must match the next PC of the expected stream.
    always @(posedge clk) begin
        if (!rst && fetch_valid && decode_ready) begin
            check_value("fetch_out", expected_packet(exp_pc), fetch_out);
            exp_pc = exp_pc + 30'd1;
            delivered++;
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (fault_seen) begin
                check_value("access_fault", 1, access_fault); // Sticky.
            end else if (!fault_armed) begin
                check_value("access_fault", 0, access_fault);
            end else if (access_fault) begin
                fault_seen = 1'b1;
            end
        end
    end

    initial begin
        #(CLK_PERIOD * (CYCLES_PER_INST * TOTAL_INSTS + MARGIN_CYCLES));
        $display("Timeout: the fetch stream stalled before all instructions were delivered");
        $display("TESTS FAILED");
        $fatal(1);
    end

    initial begin
        rst            = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        decode_ready   = 1'b0;
        fault_en       = 1'b0;
        fault_base     = FAULT_BASE;
        exp_pc         = SEQ_BASE[31:2];
        delivered      = 0;
        fault_armed    = 1'b0;
        fault_seen     = 1'b0;
        rand_state     = 32'h510d_2741;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        check_value("arvalid", 0, arvalid);
        check_value("rready", 0, rready);
        check_value("fetch_valid", 0, fetch_valid);
        check_value("refill_valid", 0, dut0.refill_valid);
        check_value("access_fault", 0, access_fault);
        rst          = 1'b0;
        decode_ready = 1'b1;

        wait_for_delivered(N_SEQ);
        redirect_to(SDRAM_BASE);
        wait_for_delivered(N_SEQ + N_SDRAM);
        redirect_to(REUSE_BASE);
        wait_for_delivered(N_SEQ + N_SDRAM + N_REUSE);

        check_single_refill(SEQ_BASE);
        check_burst_refill(SDRAM_BASE);
        check_single_refill(REUSE_BASE); // Reuse added no beats.

        while (delivered < N_SEQ + N_SDRAM + N_REUSE + N_BACKPRESSURE) begin
            rand_state   = xorshift32(rand_state);
            decode_ready = rand_state[7];
            next_drive_point();
        end
        decode_ready = 1'b1;

        check_value("access_fault", 0, access_fault);
        fault_en = 1'b1;
        redirect_to(FAULT_BASE);
        fault_armed = 1'b1;
        wait_for_delivered(TOTAL_INSTS);
        check_value("access_fault", 1, access_fault);
        check_value("fault_seen", 1, fault_seen);
        check_single_refill(FAULT_BASE);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- dv/axi_rom_model.sv
`include "fetch_defs.svh"

module axi_rom_model
    import fetch_pkg::*;
#(
    parameter int LOG_DEPTH = 256
) (
    input  logic        clk,
    input  logic        rst,

    input  logic        arvalid,
    input  axi_ar_t     ar,
    output logic        arready,
    output logic        rvalid,
    input  logic        rready,
    output axi_r_t      r,

    output logic [29:0] rom_addr,
    input  logic [31:0] rom_data,

    input  logic        fault_en,
    input  logic [31:0] fault_base,
    output int          ar_count
);

    localparam int OFFSET_BITS = $clog2(`FETCH_BLOCK_BYTES);

    axi_ar_t     ar_log [LOG_DEPTH]; // Every accepted address beat, in order.
    logic [31:0] cur_addr;
    logic [7:0]  beats_left;
    logic        incr;
    logic [1:0]  resp;
    logic        in_fault_block;

    assign in_fault_block = cur_addr[31:OFFSET_BITS] == fault_base[31:OFFSET_BITS];
    assign resp     = (fault_en && in_fault_block) ? 2'b10 : 2'b00; // SLVERR.
    assign rom_addr = cur_addr[31:2];
    assign r        = '{rom_data, resp, beats_left == 8'd0, 4'd0};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            arready    <= 1'b0;
            rvalid     <= 1'b0;
            ar_count   <= 0;
            cur_addr   <= '0;
            beats_left <= '0;
            incr       <= 1'b0;
        end else if (arvalid && arready) begin
            ar_count   <= ar_count + 1;
            cur_addr   <= ar.addr;
            beats_left <= ar.len;
            incr       <= ar.burst == BURST_INCR;
            arready    <= 1'b0;
            rvalid     <= 1'b1;
        end else if (rvalid && rready) begin
            if (beats_left == 8'd0) begin
                rvalid  <= 1'b0;
                arready <= 1'b1;
            end else begin
                beats_left <= beats_left - 8'd1;
                if (incr) begin
                    cur_addr <= cur_addr + 32'd4;
                end
            end
        end else if (!rvalid) begin
            arready <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready && ar_count < LOG_DEPTH) begin
            ar_log[ar_count] <= ar;
        end
    end

endmodule

//--- rtl/fetch_top.sv
module fetch_top
    import fetch_pkg::*;
(
    input  logic          clk,
    input  logic          rst,

    input  logic          redirect_valid,
    input  logic [29:0]   redirect_pc,

    input  logic          decode_ready,
    output logic          fetch_valid,
    output fetch_packet_t fetch_out,
    output logic          access_fault,

    output logic          arvalid,
    output axi_ar_t       ar,
    input  logic          arready,
    output logic          rready,
    input  logic          rvalid,
    input  axi_r_t        r
);

    logic [31:0]  lookup_addr;
    logic         hit;
    logic [31:0]  hit_data;
    logic         refill_valid;
    cache_block_t refill_block;

    fetch_unit u_fetch_unit (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .decode_ready   (decode_ready),
        .fetch_valid    (fetch_valid),
        .fetch_out      (fetch_out),
        .access_fault   (access_fault),
        .lookup_addr    (lookup_addr),
        .hit            (hit),
        .hit_data       (hit_data),
        .refill_valid   (refill_valid),
        .refill_block   (refill_block),
        .arvalid        (arvalid),
        .ar             (ar),
        .arready        (arready),
        .rready         (rready),
        .rvalid         (rvalid),
        .r              (r)
    );

    icache u_icache (
        .clk          (clk),
        .rst          (rst),
        .lookup_addr  (lookup_addr),
        .hit          (hit),
        .hit_data     (hit_data),
        .refill_valid (refill_valid),
        .refill_block (refill_block)
    );

endmodule

//--- rtl/icache.sv
`include "fetch_defs.svh"

module icache
    import fetch_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    input  logic [31:0]  lookup_addr,
    output logic         hit,
    output logic [31:0]  hit_data,

    input  logic         refill_valid,
    input  cache_block_t refill_block
);

    localparam int SETS        = `FETCH_ICACHE_SETS;
    localparam int OFFSET_BITS = $clog2(`FETCH_BLOCK_BYTES);
    localparam int INDEX_BITS  = $clog2(SETS);
    localparam int WORD_BITS   = OFFSET_BITS - 2;
    localparam int TAG_LO      = OFFSET_BITS + INDEX_BITS;
    localparam int TAG_BITS    = 32 - TAG_LO;

    logic [SETS-1:0]       valid_q;
    logic [TAG_BITS-1:0]   tag_mem [SETS];
    cache_block_t          data_mem [SETS];

    logic [INDEX_BITS-1:0] index;
    logic [TAG_BITS-1:0]   tag;
    logic [WORD_BITS-1:0]  word_sel;
    cache_block_t          line;

    // Split the byte address into tag, line index and word offset.
    assign tag      = lookup_addr[31:TAG_LO];
    assign index    = lookup_addr[TAG_LO-1:OFFSET_BITS];
    assign word_sel = lookup_addr[OFFSET_BITS-1:2];

    assign line     = data_mem[index];
    assign hit      = valid_q[index] && (tag_mem[index] == tag);
    assign hit_data = line[word_sel*32 +: 32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0; // All lines empty.
        end else if (refill_valid) begin
            valid_q[index] <= 1'b1;
        end
    end

    // Tag and block land together with the valid bit.
    always_ff @(posedge clk) begin
        if (refill_valid) begin
            tag_mem[index]  <= tag;
            data_mem[index] <= refill_block;
        end
    end

endmodule

//--- rtl/fetch_unit.sv
`include "fetch_defs.svh"

module fetch_unit
    import fetch_pkg::*;
(
    input  logic          clk,
    input  logic          rst,

    input  logic          redirect_valid,
    input  logic [29:0]   redirect_pc,

    input  logic          decode_ready,
    output logic          fetch_valid,
    output fetch_packet_t fetch_out,
    output logic          access_fault,

    output logic [31:0]   lookup_addr,
    input  logic          hit,
    input  logic [31:0]   hit_data,
    output logic          refill_valid,
    output cache_block_t  refill_block,

    output logic          arvalid,
    output axi_ar_t       ar,
    input  logic          arready,
    output logic          rready,
    input  logic          rvalid,
    input  axi_r_t        r
);

    localparam int BLOCK_WORDS = `FETCH_BLOCK_BYTES / 4;
    localparam int OFFSET_BITS = $clog2(`FETCH_BLOCK_BYTES);
    localparam int CNT_BITS    = OFFSET_BITS - 2;

    localparam logic [31:0]         PC_RESET  = `FETCH_PC_RESET;
    localparam logic [CNT_BITS-1:0] LAST_BEAT = CNT_BITS'(BLOCK_WORDS - 1);

    typedef enum logic {
        ST_IDLE,
        ST_REFILL
    } state_e;

    state_e              state;
    logic [29:0]         pc_q;
    logic [29:0]         pc_next;
    logic [31:0]         block_base;
    logic                is_sdram;
    logic [CNT_BITS-1:0] beat_cnt;
    logic [CNT_BITS-1:0] beat_cnt_next;
    logic                take_hit;
    logic                start_miss;
    logic                ar_hs;
    logic                r_hs;
    logic                last_beat;

    assign lookup_addr = {pc_q, 2'b00};
    assign pc_next     = redirect_valid ? redirect_pc : pc_q + 30'd1;

    assign block_base = {lookup_addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    assign is_sdram   = (block_base[31:28] == `FETCH_SDRAM_LO) ||
                        (block_base[31:28] == `FETCH_SDRAM_HI);

    assign take_hit   = (state == ST_IDLE) && decode_ready && hit;
    assign start_miss = (state == ST_IDLE) && decode_ready && !hit;

    assign ar_hs = arvalid && arready;
    assign r_hs  = rvalid && rready;

    // A burst ends on last, single reads end on the word count.
    assign last_beat     = is_sdram ? r.last : (beat_cnt == LAST_BEAT);
    assign beat_cnt_next = beat_cnt + 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= ST_IDLE;
            pc_q         <= PC_RESET[31:2];
            fetch_valid  <= 1'b0;
            arvalid      <= 1'b0;
            rready       <= 1'b0;
            refill_valid <= 1'b0;
            access_fault <= 1'b0;
            beat_cnt     <= '0;
        end else begin
            refill_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (decode_ready) begin
                        fetch_valid <= hit && !redirect_valid; // Redirect drops it.
                        if (hit) begin
                            pc_q <= pc_next;
                        end else begin
                            state   <= ST_REFILL;
                            arvalid <= 1'b1;
                        end
                    end
                end
                ST_REFILL: begin
                    if (ar_hs) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                    end
                    if (r_hs) begin
                        if (r.resp != 2'b00) begin
                            access_fault <= 1'b1; // Sticky until reset.
                        end
                        if (last_beat) begin
                            rready       <= 1'b0;
                            refill_valid <= 1'b1;
                            beat_cnt     <= '0;
                        end else begin
                            beat_cnt <= beat_cnt_next;
                            if (!is_sdram) begin
                                rready  <= 1'b0;
                                arvalid <= 1'b1; // Next single read.
                            end
                        end
                    end
                    // Line is written this cycle, lookup hits on the next.
                    if (refill_valid) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_hit) begin
            fetch_out.pc   <= pc_q;
            fetch_out.inst <= hit_data;
        end
        if (start_miss) begin
            ar.addr  <= block_base;
            ar.id    <= 4'd0;
            ar.len   <= is_sdram ? 8'(BLOCK_WORDS - 1) : 8'd0;
            ar.size  <= 3'd2; // Four bytes per beat.
            ar.burst <= is_sdram ? BURST_INCR : BURST_FIXED;
        end
        if (r_hs) begin
            refill_block[beat_cnt*32 +: 32] <= r.data;
            if (!last_beat && !is_sdram) begin
                ar.addr <= {block_base[31:OFFSET_BITS], beat_cnt_next, 2'b00};
            end
        end
    end

endmodule

//--- rtl/fetch_pkg.sv
`include "fetch_defs.svh"

package fetch_pkg;

    // AXI burst encodings used by the fetch unit.
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01
    } axi_burst_e;

    // One whole cache block as it moves from the fetch unit to the cache.
    typedef logic [`FETCH_BLOCK_BYTES*8-1:0] cache_block_t;

    // Packet handed to decode.
    typedef struct packed {
        logic [29:0] pc;   // Word address.
        logic [31:0] inst;
    } fetch_packet_t;

    // AXI read address beat.
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  id;
        logic [7:0]  len;
        logic [2:0]  size;
        axi_burst_e  burst;
    } axi_ar_t;

    // AXI read data beat.
    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
        logic [3:0]  id;
    } axi_r_t;

endpackage

//--- rtl/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Byte address of the first instruction after reset.
`define FETCH_PC_RESET 32'h3000_0000

// Cache block size in bytes, four 32-bit words.
`define FETCH_BLOCK_BYTES 16

// Number of direct-mapped cache lines.
`define FETCH_ICACHE_SETS 16

// Top address nibbles of the SDRAM window.
`define FETCH_SDRAM_LO 4'hA
`define FETCH_SDRAM_HI 4'hB

`endif
